// File: hw/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DATA_W          32
`define REG_ADDR_W      5
`define LINK_REG        5'd31

// Major opcodes, inst[31:26]
`define OPC_SPECIAL     6'b000000
`define OPC_J           6'b000010
`define OPC_JAL         6'b000011
`define OPC_BEQ         6'b000100
`define OPC_BNE         6'b000101
`define OPC_BLEZ        6'b000110
`define OPC_BGTZ        6'b000111
`define OPC_ADDI        6'b001000
`define OPC_ADDIU       6'b001001
`define OPC_ANDI        6'b001100
`define OPC_ORI         6'b001101
`define OPC_XORI        6'b001110
`define OPC_LUI         6'b001111
`define OPC_LW          6'b100011
`define OPC_SW          6'b101011

// SPECIAL function field, inst[5:0]
`define FUNCT_SLL       6'b000000
`define FUNCT_SRL       6'b000010
`define FUNCT_SRA       6'b000011
`define FUNCT_SLLV      6'b000100
`define FUNCT_SRLV      6'b000110
`define FUNCT_SRAV      6'b000111
`define FUNCT_JR        6'b001000
`define FUNCT_JALR      6'b001001
`define FUNCT_ADD       6'b100000
`define FUNCT_ADDU      6'b100001
`define FUNCT_SUB       6'b100010
`define FUNCT_SUBU      6'b100011
`define FUNCT_AND       6'b100100
`define FUNCT_OR        6'b100101
`define FUNCT_XOR       6'b100110
`define FUNCT_NOR       6'b100111
`define FUNCT_SLT       6'b101010
`define FUNCT_SLTU      6'b101011

`endif

// File: hw/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Execute-stage operation codes
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_JR    = 8'b0000_1000,
        ALU_JALR  = 8'b0000_1001,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_J     = 8'b0100_1111,
        ALU_JAL   = 8'b0101_0000,
        ALU_BEQ   = 8'b0101_0001,
        ALU_BNE   = 8'b0101_0010,
        ALU_BLEZ  = 8'b0101_0011,
        ALU_BGTZ  = 8'b0101_0100,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_SLL   = 8'b0111_1100,
        ALU_LW    = 8'b1110_0011,
        ALU_SW    = 8'b1110_1011
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP       = 3'b000,
        SEL_LOGIC     = 3'b001,
        SEL_SHIFT     = 3'b010,
        SEL_ARITH     = 3'b100,
        SEL_JUMP      = 3'b110,
        SEL_LOADSTORE = 3'b111
    } alu_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_JR, BR_J, BR_BEQ, BR_BNE, BR_BGTZ, BR_BLEZ
    } br_kind_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      is_load;
    } fwd_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        logic      rs_read;
        logic      rt_read;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t wd;
        logic      wreg;
        word_t     imm;
        br_kind_e  br_kind;
        logic      link;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        word_t     opnd1;
        word_t     opnd2;
        reg_addr_t wd;
        logic      wreg;
        logic      br_taken;
        word_t     br_target;
        word_t     link_addr;
        logic      in_delay_slot;
        logic      illegal;
    } id_ex_t;

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module inst_decoder
    import decode_pkg::*;
(
    input  word_t inst_i,
    output ctrl_t ctrl_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] shamt;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      imm_zext;
    logic       known;

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign shamt    = inst_i[10:6];
    assign funct    = inst_i[5:0];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'h0000, inst_i[15:0]};

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.rs_addr = rs;
        ctrl_o.rt_addr = rt;
        ctrl_o.wd      = rd;
        known          = 1'b1;
        case (opcode)
            `OPC_SPECIAL: begin
                ctrl_o.rs_read = 1'b1;
                ctrl_o.rt_read = 1'b1;
                ctrl_o.wreg    = 1'b1;
                case (funct)
                    `FUNCT_OR:   ctrl_o.alu_op = ALU_OR;
                    `FUNCT_AND:  ctrl_o.alu_op = ALU_AND;
                    `FUNCT_XOR:  ctrl_o.alu_op = ALU_XOR;
                    `FUNCT_NOR:  ctrl_o.alu_op = ALU_NOR;
                    `FUNCT_ADD:  ctrl_o.alu_op = ALU_ADD;
                    `FUNCT_ADDU: ctrl_o.alu_op = ALU_ADDU;
                    `FUNCT_SUB:  ctrl_o.alu_op = ALU_SUB;
                    `FUNCT_SUBU: ctrl_o.alu_op = ALU_SUBU;
                    `FUNCT_SLT:  ctrl_o.alu_op = ALU_SLT;
                    `FUNCT_SLTU: ctrl_o.alu_op = ALU_SLTU;
                    `FUNCT_SLL, `FUNCT_SLLV: ctrl_o.alu_op = ALU_SLL;
                    `FUNCT_SRL, `FUNCT_SRLV: ctrl_o.alu_op = ALU_SRL;
                    `FUNCT_SRA, `FUNCT_SRAV: ctrl_o.alu_op = ALU_SRA;
                    `FUNCT_JR:   ctrl_o.alu_op = ALU_JR;
                    `FUNCT_JALR: ctrl_o.alu_op = ALU_JALR;
                    default:     known = 1'b0;
                endcase
                case (funct)
                    // Constant shifts take the amount as operand 1
                    `FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA: begin
                        ctrl_o.rs_read = 1'b0;
                        ctrl_o.imm     = word_t'(shamt);
                        known          = (rs == '0);
                    end
                    `FUNCT_JR, `FUNCT_JALR: begin
                        ctrl_o.rt_read = 1'b0;
                        ctrl_o.wreg    = (funct == `FUNCT_JALR);
                        ctrl_o.link    = (funct == `FUNCT_JALR);
                        ctrl_o.br_kind = BR_JR;
                    end
                    default: known = known && (shamt == 5'd0);
                endcase
            end
            `OPC_ORI, `OPC_ANDI, `OPC_XORI, `OPC_LUI, `OPC_ADDI, `OPC_ADDIU, `OPC_LW: begin
                ctrl_o.rs_read = 1'b1;
                ctrl_o.wreg    = 1'b1;
                ctrl_o.wd      = rt;
                ctrl_o.imm     = imm_sext;
                case (opcode)
                    `OPC_ORI, `OPC_LUI: ctrl_o.alu_op = ALU_OR;
                    `OPC_ANDI:  ctrl_o.alu_op = ALU_AND;
                    `OPC_XORI:  ctrl_o.alu_op = ALU_XOR;
                    `OPC_ADDI:  ctrl_o.alu_op = ALU_ADDI;
                    `OPC_ADDIU: ctrl_o.alu_op = ALU_ADDIU;
                    default:    ctrl_o.alu_op = ALU_LW;
                endcase
                if (opcode inside {`OPC_ORI, `OPC_ANDI, `OPC_XORI}) begin
                    ctrl_o.imm = imm_zext;
                end else if (opcode == `OPC_LUI) begin
                    ctrl_o.imm = {inst_i[15:0], 16'h0000};
                end
            end
            `OPC_SW: begin
                ctrl_o.alu_op  = ALU_SW;
                ctrl_o.rs_read = 1'b1;
                ctrl_o.rt_read = 1'b1;
                ctrl_o.imm     = imm_sext;
            end
            `OPC_BEQ, `OPC_BNE, `OPC_BGTZ, `OPC_BLEZ: begin
                ctrl_o.rs_read = 1'b1;
                ctrl_o.rt_read = (opcode == `OPC_BEQ) || (opcode == `OPC_BNE);
                ctrl_o.imm     = imm_sext;
                case (opcode)
                    `OPC_BEQ: ctrl_o.br_kind = BR_BEQ;
                    `OPC_BNE: ctrl_o.br_kind = BR_BNE;
                    `OPC_BGTZ: ctrl_o.br_kind = BR_BGTZ;
                    default:  ctrl_o.br_kind = BR_BLEZ;
                endcase
                case (opcode)
                    `OPC_BEQ: ctrl_o.alu_op = ALU_BEQ;
                    `OPC_BNE: ctrl_o.alu_op = ALU_BNE;
                    `OPC_BGTZ: ctrl_o.alu_op = ALU_BGTZ;
                    default:  ctrl_o.alu_op = ALU_BLEZ;
                endcase
            end
            `OPC_J, `OPC_JAL: begin
                ctrl_o.alu_op  = (opcode == `OPC_JAL) ? ALU_JAL : ALU_J;
                ctrl_o.br_kind = BR_J;
                ctrl_o.wreg    = (opcode == `OPC_JAL);
                ctrl_o.link    = (opcode == `OPC_JAL);
                ctrl_o.wd      = `LINK_REG;
            end
            default: known = 1'b0;
        endcase

        // Unknown words leave a flagged bubble
        if (!known) begin
            ctrl_o.alu_op  = ALU_NOP;
            ctrl_o.rs_read = 1'b0;
            ctrl_o.rt_read = 1'b0;
            ctrl_o.wreg    = 1'b0;
            ctrl_o.imm     = '0;
            ctrl_o.br_kind = BR_NONE;
            ctrl_o.link    = 1'b0;
            ctrl_o.illegal = 1'b1;
        end

        case (ctrl_o.alu_op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: ctrl_o.alu_sel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA: ctrl_o.alu_sel = SEL_SHIFT;
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
            ALU_ADDI, ALU_ADDIU: ctrl_o.alu_sel = SEL_ARITH;
            ALU_LW, ALU_SW: ctrl_o.alu_sel = SEL_LOADSTORE;
            ALU_JR, ALU_JALR, ALU_J, ALU_JAL, ALU_BEQ, ALU_BNE, ALU_BGTZ,
            ALU_BLEZ: ctrl_o.alu_sel = SEL_JUMP;
            default: ctrl_o.alu_sel = SEL_NOP;
        endcase
    end

endmodule

// File: hw/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch
    import decode_pkg::*;
(
    input  logic      read_en_i,
    input  reg_addr_t addr_i,
    input  word_t     imm_i,
    input  word_t     rf_data_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output word_t     opnd_o,
    output logic      stall_o
);

    logic ex_hit;
    logic mem_hit;
    logic load_hit;

    assign ex_hit   = ex_fwd_i.wreg && (ex_fwd_i.waddr == addr_i);
    assign mem_hit  = mem_fwd_i.wreg && (mem_fwd_i.waddr == addr_i);
    // Load data is not ready until the memory stage
    assign load_hit = ex_fwd_i.is_load && (ex_fwd_i.waddr == addr_i);

    always_comb begin
        if (!read_en_i) begin
            opnd_o = imm_i;
        end else if (ex_hit) begin
            opnd_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            opnd_o = mem_fwd_i.wdata;
        end else begin
            opnd_o = rf_data_i;
        end
    end

    assign stall_o = read_en_i && load_hit;

endmodule

// File: hw/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        accept_i,
    input  word_t       pc_i,
    input  logic [25:0] inst_index_i,
    input  word_t       imm_i,
    input  br_kind_e    br_kind_i,
    input  logic        link_i,
    input  word_t       opnd1_i,
    input  word_t       opnd2_i,
    output logic        taken_o,
    output word_t       target_o,
    output word_t       link_addr_o,
    output logic        in_delay_slot_o
);

    word_t pc_plus_4;
    word_t pc_plus_8;
    word_t br_dest;
    word_t raw_target;
    logic  in_delay_q;

    assign pc_plus_4 = pc_i + 32'd4;
    assign pc_plus_8 = pc_i + 32'd8;
    assign br_dest   = pc_plus_4 + {imm_i[29:0], 2'b00};

    always_comb begin
        taken_o    = 1'b0;
        raw_target = br_dest;
        case (br_kind_i)
            BR_JR: begin
                taken_o    = 1'b1;
                raw_target = opnd1_i;
            end
            BR_J: begin
                taken_o    = 1'b1;
                raw_target = {pc_plus_4[31:28], inst_index_i, 2'b00};
            end
            BR_BEQ:  taken_o = (opnd1_i == opnd2_i);
            BR_BNE:  taken_o = (opnd1_i != opnd2_i);
            BR_BGTZ: taken_o = !opnd1_i[31] && (opnd1_i != '0);
            BR_BLEZ: taken_o = opnd1_i[31] || (opnd1_i == '0);
            default: taken_o = 1'b0;
        endcase
    end

    // Target reads as zero when no branch is taken
    assign target_o    = taken_o ? raw_target : '0;
    assign link_addr_o = link_i ? pc_plus_8 : '0;

    // Instruction after any branch or jump sits in its delay slot
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_delay_q <= 1'b0;
        end else if (accept_i) begin
            in_delay_q <= (br_kind_i != BR_NONE);
        end
    end

    assign in_delay_slot_o = in_delay_q;

endmodule

// File: hw/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  id_ex_t data_i,
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output id_ex_t data_o
);

    logic   valid_q;
    id_ex_t data_q;

    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign data_o      = data_q;

    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_o)
    ) else $error("ID/EX bundle changed while stalled downstream");

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  fetch_t    fetch_i,
    output reg_addr_t rf_rs_addr_o,
    output reg_addr_t rf_rt_addr_o,
    input  word_t     rf_rs_data_i,
    input  word_t     rf_rt_data_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output id_ex_t    out_o
);

    ctrl_t  ctrl;
    word_t  opnd1;
    word_t  opnd2;
    logic   rs_stall;
    logic   rt_stall;
    logic   stall;
    logic   reg_ready;
    logic   accept;
    logic   br_taken;
    word_t  br_target;
    word_t  link_addr;
    logic   in_delay_slot;
    id_ex_t bundle;

    assign stall        = rs_stall | rt_stall;
    assign in_ready_o   = reg_ready && !stall;
    assign accept       = in_valid_i && in_ready_o;
    assign rf_rs_addr_o = ctrl.rs_addr;
    assign rf_rt_addr_o = ctrl.rt_addr;

    inst_decoder i_decoder (
        .inst_i (fetch_i.inst),
        .ctrl_o (ctrl)
    );

    operand_fetch i_rs_fetch (
        .read_en_i (ctrl.rs_read),
        .addr_i    (ctrl.rs_addr),
        .imm_i     (ctrl.imm),
        .rf_data_i (rf_rs_data_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .opnd_o    (opnd1),
        .stall_o   (rs_stall)
    );

    operand_fetch i_rt_fetch (
        .read_en_i (ctrl.rt_read),
        .addr_i    (ctrl.rt_addr),
        .imm_i     (ctrl.imm),
        .rf_data_i (rf_rt_data_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .opnd_o    (opnd2),
        .stall_o   (rt_stall)
    );

    branch_resolve i_branch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .accept_i        (accept),
        .pc_i            (fetch_i.pc),
        .inst_index_i    (fetch_i.inst[25:0]),
        .imm_i           (ctrl.imm),
        .br_kind_i       (ctrl.br_kind),
        .link_i          (ctrl.link),
        .opnd1_i         (opnd1),
        .opnd2_i         (opnd2),
        .taken_o         (br_taken),
        .target_o        (br_target),
        .link_addr_o     (link_addr),
        .in_delay_slot_o (in_delay_slot)
    );

    always_comb begin
        bundle.pc            = fetch_i.pc;
        bundle.alu_op        = ctrl.alu_op;
        bundle.alu_sel       = ctrl.alu_sel;
        bundle.opnd1         = opnd1;
        bundle.opnd2         = opnd2;
        bundle.wd            = ctrl.wd;
        bundle.wreg          = ctrl.wreg;
        bundle.br_taken      = br_taken;
        bundle.br_target     = br_target;
        bundle.link_addr     = link_addr;
        bundle.in_delay_slot = in_delay_slot;
        bundle.illegal       = ctrl.illegal;
    end

    // Held back while a source waits on a load
    id_ex_reg i_id_ex (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i && !stall),
        .in_ready_o  (reg_ready),
        .data_i      (bundle),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .data_o      (out_o)
    );

    a_accept_reaches_output: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        accept |=> out_valid_o && (out_o.pc == $past(fetch_i.pc))
    ) else $error("accepted instruction did not reach the ID/EX register");

endmodule

// File: verif/id_stage_tb.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module id_stage_tb
    import decode_pkg::*;
;

    localparam int CLK_HALF       = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_VEC = 40;
    localparam fwd_t NO_FWD       = '0;

    // Flags are {wreg, br_taken, in_delay_slot, illegal}
    typedef struct packed {
        word_t     inst;
        word_t     pc;
        fwd_t      ex_fwd;
        fwd_t      mem_fwd;
        int        stall;
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        word_t     opnd1;
        word_t     opnd2;
        reg_addr_t wd;
        logic [3:0] flags;
        word_t     br_target;
        word_t     link_addr;
    } vec_t;

    logic      clk = 1'b0;
    logic      rst_n_i;
    logic      in_valid_i;
    logic      in_ready_o;
    fetch_t    fetch_i;
    reg_addr_t rf_rs_addr_o;
    reg_addr_t rf_rt_addr_o;
    word_t     rf_rs_data_i;
    word_t     rf_rt_data_i;
    fwd_t      ex_fwd_i;
    fwd_t      mem_fwd_i;
    logic      out_valid_o;
    logic      out_ready_i;
    id_ex_t    out_o;

    vec_t  vecs[$];
    string names[$];
    int    pending[$];
    int    errors = 0;
    int    checked = 0;
    int    next_idx = 0;
    int    stall_left = 0;
    logic  table_ready = 1'b0;
    logic  exp_ready;
    vec_t  cur;

    always #CLK_HALF clk = ~clk;

    id_stage i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .fetch_i      (fetch_i),
        .rf_rs_addr_o (rf_rs_addr_o),
        .rf_rt_addr_o (rf_rt_addr_o),
        .rf_rs_data_i (rf_rs_data_i),
        .rf_rt_data_i (rf_rt_data_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_o        (out_o)
    );

    // Register file model
    function automatic word_t rf_value(input reg_addr_t r);
        return word_t'(r) * 32'h0101_0101;
    endfunction

    assign rf_rs_data_i = rf_value(rf_rs_addr_o);
    assign rf_rt_data_i = rf_value(rf_rt_addr_o);

    function automatic word_t enc_r(input int rs, input int rt, input int rd,
                                    input int shamt, input logic [5:0] funct);
        return {`OPC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] opc, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {opc, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t enc_j(input logic [5:0] opc, input logic [25:0] index);
        return {opc, index};
    endfunction

    function automatic fwd_t fwd_rep(input reg_addr_t waddr, input word_t wdata,
                                     input logic is_load);
        fwd_t f;
        f.wreg    = 1'b1;
        f.waddr   = waddr;
        f.wdata   = wdata;
        f.is_load = is_load;
        return f;
    endfunction

    task automatic add_vec(input string name, input word_t inst, input word_t pc,
                           input fwd_t ex, input fwd_t mem, input int stall,
                           input alu_op_e op, input alu_sel_e sel, input word_t o1,
                           input word_t o2, input int wd, input logic [3:0] flags,
                           input word_t target, input word_t link);
        vec_t v;
        v.inst      = inst;
        v.pc        = pc;
        v.ex_fwd    = ex;
        v.mem_fwd   = mem;
        v.stall     = stall;
        v.alu_op    = op;
        v.alu_sel   = sel;
        v.opnd1     = o1;
        v.opnd2     = o2;
        v.wd        = wd[4:0];
        v.flags     = flags;
        v.br_target = target;
        v.link_addr = link;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    task automatic build_table();
        add_vec("or", enc_r(1, 2, 3, 0, `FUNCT_OR), 32'h1000, NO_FWD, NO_FWD, 0,
                ALU_OR, SEL_LOGIC, rf_value(5'd1), rf_value(5'd2), 3, 4'b1000, 32'h0, 32'h0);
        add_vec("addi_sext", enc_i(`OPC_ADDI, 4, 5, 16'hfff0), 32'h1004, NO_FWD, NO_FWD, 0,
                ALU_ADDI, SEL_ARITH, rf_value(5'd4), 32'hffff_fff0, 5, 4'b1000, 32'h0, 32'h0);
        add_vec("ori_zext", enc_i(`OPC_ORI, 1, 6, 16'h8001), 32'h1008, NO_FWD, NO_FWD, 0,
                ALU_OR, SEL_LOGIC, rf_value(5'd1), 32'h0000_8001, 6, 4'b1000, 32'h0, 32'h0);
        add_vec("lui", enc_i(`OPC_LUI, 0, 7, 16'h1234), 32'h100c, NO_FWD, NO_FWD, 0,
                ALU_OR, SEL_LOGIC, 32'h0, 32'h1234_0000, 7, 4'b1000, 32'h0, 32'h0);
        add_vec("sll_shamt", enc_r(0, 2, 8, 5, `FUNCT_SLL), 32'h1010, NO_FWD, NO_FWD, 0,
                ALU_SLL, SEL_SHIFT, 32'h5, rf_value(5'd2), 8, 4'b1000, 32'h0, 32'h0);
        add_vec("srav", enc_r(3, 4, 9, 0, `FUNCT_SRAV), 32'h1014, NO_FWD, NO_FWD, 0,
                ALU_SRA, SEL_SHIFT, rf_value(5'd3), rf_value(5'd4), 9, 4'b1000, 32'h0, 32'h0);
        add_vec("sub", enc_r(5, 6, 10, 0, `FUNCT_SUB), 32'h1018, NO_FWD, NO_FWD, 0,
                ALU_SUB, SEL_ARITH, rf_value(5'd5), rf_value(5'd6), 10, 4'b1000, 32'h0, 32'h0);
        // Both later stages write r1, execute wins
        add_vec("fwd_ex_over_mem", enc_r(1, 2, 11, 0, `FUNCT_ADDU), 32'h101c,
                fwd_rep(5'd1, 32'haaaa_0001, 1'b0), fwd_rep(5'd1, 32'hbbbb_0001, 1'b0), 0,
                ALU_ADDU, SEL_ARITH, 32'haaaa_0001, rf_value(5'd2), 11, 4'b1000, 32'h0, 32'h0);
        add_vec("fwd_mem_over_rf", enc_r(1, 2, 12, 0, `FUNCT_AND), 32'h1020,
                fwd_rep(5'd3, 32'hcccc_0003, 1'b0), fwd_rep(5'd2, 32'hdddd_0002, 1'b0), 0,
                ALU_AND, SEL_LOGIC, rf_value(5'd1), 32'hdddd_0002, 12, 4'b1000, 32'h0, 32'h0);
        // Load data arrives through the memory stage after the stall
        add_vec("load_use", enc_r(4, 5, 13, 0, `FUNCT_XOR), 32'h1024,
                NO_FWD, fwd_rep(5'd4, 32'h4444_cafe, 1'b0), 3,
                ALU_XOR, SEL_LOGIC, 32'h4444_cafe, rf_value(5'd5), 13, 4'b1000, 32'h0, 32'h0);
        add_vec("load_no_match", enc_i(`OPC_ADDIU, 6, 14, 16'h0010), 32'h1028,
                fwd_rep(5'd7, 32'h7777_0007, 1'b1), NO_FWD, 0,
                ALU_ADDIU, SEL_ARITH, rf_value(5'd6), 32'h10, 14, 4'b1000, 32'h0, 32'h0);
        add_vec("sw", enc_i(`OPC_SW, 8, 9, 16'h0004), 32'h102c, NO_FWD, NO_FWD, 0,
                ALU_SW, SEL_LOADSTORE, rf_value(5'd8), rf_value(5'd9), 0, 4'b0000,
                32'h0, 32'h0);
        add_vec("beq_taken", enc_i(`OPC_BEQ, 3, 3, 16'h0010), 32'h1030, NO_FWD, NO_FWD, 0,
                ALU_BEQ, SEL_JUMP, rf_value(5'd3), rf_value(5'd3), 0, 4'b0100,
                32'h1074, 32'h0);
        add_vec("slot_after_beq", enc_r(1, 1, 15, 0, `FUNCT_NOR), 32'h1034, NO_FWD, NO_FWD, 0,
                ALU_NOR, SEL_LOGIC, rf_value(5'd1), rf_value(5'd1), 15, 4'b1010,
                32'h0, 32'h0);
        add_vec("after_slot", enc_r(2, 3, 16, 0, `FUNCT_SLT), 32'h1038, NO_FWD, NO_FWD, 0,
                ALU_SLT, SEL_ARITH, rf_value(5'd2), rf_value(5'd3), 16, 4'b1000,
                32'h0, 32'h0);
        add_vec("bne_not_taken", enc_i(`OPC_BNE, 5, 5, 16'hfffc), 32'h103c, NO_FWD, NO_FWD, 0,
                ALU_BNE, SEL_JUMP, rf_value(5'd5), rf_value(5'd5), 31, 4'b0000,
                32'h0, 32'h0);
        add_vec("bgtz_negative", enc_i(`OPC_BGTZ, 1, 0, 16'h0020), 32'h1040,
                fwd_rep(5'd1, 32'h8000_0000, 1'b0), NO_FWD, 0,
                ALU_BGTZ, SEL_JUMP, 32'h8000_0000, 32'h20, 0, 4'b0010, 32'h0, 32'h0);
        add_vec("blez_zero", enc_i(`OPC_BLEZ, 0, 0, 16'hfff8), 32'h1044, NO_FWD, NO_FWD, 0,
                ALU_BLEZ, SEL_JUMP, 32'h0, 32'hffff_fff8, 31, 4'b0110, 32'h1028, 32'h0);
        add_vec("jal", enc_j(`OPC_JAL, 26'h000_0400), 32'h4000_2000, NO_FWD, NO_FWD, 0,
                ALU_JAL, SEL_JUMP, 32'h0, 32'h0, 31, 4'b1110, 32'h4000_1000, 32'h4000_2008);
        add_vec("j", enc_j(`OPC_J, 26'h3ff_fff0), 32'h4000_2004, NO_FWD, NO_FWD, 0,
                ALU_J, SEL_JUMP, 32'h0, 32'h0, 31, 4'b0110, 32'h4fff_ffc0, 32'h0);
        add_vec("jalr", enc_r(6, 0, 30, 0, `FUNCT_JALR), 32'h4000_2008, NO_FWD, NO_FWD, 0,
                ALU_JALR, SEL_JUMP, rf_value(5'd6), 32'h0, 30, 4'b1110,
                rf_value(5'd6), 32'h4000_2010);
        add_vec("jr_fwd", enc_r(7, 0, 0, 0, `FUNCT_JR), 32'h4000_200c,
                fwd_rep(5'd7, 32'h0000_3000, 1'b0), NO_FWD, 0,
                ALU_JR, SEL_JUMP, 32'h3000, 32'h0, 0, 4'b0110, 32'h3000, 32'h0);
        add_vec("illegal", 32'hfc00_0000, 32'h4000_2010, NO_FWD, NO_FWD, 0,
                ALU_NOP, SEL_NOP, 32'h0, 32'h0, 0, 4'b0011, 32'h0, 32'h0);
        add_vec("after_illegal", enc_i(`OPC_XORI, 2, 17, 16'hffff), 32'h4000_2014,
                NO_FWD, NO_FWD, 0,
                ALU_XOR, SEL_LOGIC, rf_value(5'd2), 32'h0000_ffff, 17, 4'b1000, 32'h0, 32'h0);
    endtask

    task automatic compare(input string name, input string field,
                           input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_output();
        int   i;
        vec_t v;
        if (pending.size() == 0) begin
            errors++;
            $display("Output bundle appeared with no instruction outstanding");
            return;
        end
        i = pending.pop_front();
        v = vecs[i];
        checked++;
        compare(names[i], "pc", v.pc, out_o.pc);
        compare(names[i], "alu_op", word_t'(v.alu_op), word_t'(out_o.alu_op));
        compare(names[i], "alu_sel", word_t'(v.alu_sel), word_t'(out_o.alu_sel));
        compare(names[i], "opnd1", v.opnd1, out_o.opnd1);
        compare(names[i], "opnd2", v.opnd2, out_o.opnd2);
        compare(names[i], "wd", word_t'(v.wd), word_t'(out_o.wd));
        compare(names[i], "wreg", word_t'(v.flags[3]), word_t'(out_o.wreg));
        compare(names[i], "br_taken", word_t'(v.flags[2]), word_t'(out_o.br_taken));
        compare(names[i], "br_target", v.br_target, out_o.br_target);
        compare(names[i], "link_addr", v.link_addr, out_o.link_addr);
        compare(names[i], "in_delay_slot", word_t'(v.flags[1]),
                word_t'(out_o.in_delay_slot));
        compare(names[i], "illegal", word_t'(v.flags[0]), word_t'(out_o.illegal));
    endtask

    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + CYCLES_PER_VEC * vecs.size()) @(posedge clk);
        $display("Timeout after %0d of %0d bundles, the stage stopped making progress",
                 checked, vecs.size());
        $display("Checked %0d bundles, %0d errors", checked, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        fetch_i     = '0;
        ex_fwd_i    = '0;
        mem_fwd_i   = '0;
        out_ready_i = 1'b0;
        void'($urandom(32'h9eb6701a));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        #(CLK_HALF - 1);
        if (out_valid_o !== 1'b0) begin
            errors++;
            $display("out_valid_o is not low after reset");
        end
        if (in_ready_o !== 1'b1) begin
            errors++;
            $display("in_ready_o is not high after reset with no stall");
        end

        stall_left = vecs[0].stall;
        while (checked < vecs.size()) begin
            @(negedge clk);
            out_ready_i = ($urandom % 3) != 0;
            if (next_idx < vecs.size()) begin
                cur          = vecs[next_idx];
                in_valid_i   = 1'b1;
                fetch_i.pc   = cur.pc;
                fetch_i.inst = cur.inst;
                mem_fwd_i    = cur.mem_fwd;
                // Execute stage reports a load into the first source
                if (stall_left > 0) begin
                    ex_fwd_i = fwd_rep(cur.inst[25:21], 32'hdead_beef, 1'b1);
                end else begin
                    ex_fwd_i = cur.ex_fwd;
                end
            end else begin
                in_valid_i = 1'b0;
                ex_fwd_i   = '0;
                mem_fwd_i  = '0;
            end
            #(CLK_HALF - 1);
            if (out_valid_o !== (pending.size() != 0)) begin
                errors++;
                $display("out_valid_o does not follow the accepted instructions");
            end
            if (out_valid_o && out_ready_i) begin
                check_output();
            end
            if (in_valid_i) begin
                exp_ready = (stall_left == 0) && ((pending.size() == 0) || out_ready_i);
                if (in_ready_o !== exp_ready) begin
                    errors++;
                    $display("MISMATCH %s in_ready expected %b actual %b",
                             names[next_idx], exp_ready, in_ready_o);
                end
                if (stall_left > 0) begin
                    stall_left--;
                end
                if (in_ready_o) begin
                    pending.push_back(next_idx);
                    next_idx++;
                    if (next_idx < vecs.size()) begin
                        stall_left = vecs[next_idx].stall;
                    end
                end
            end
        end

        $display("Checked %0d bundles, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/branch_resolve.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/id_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module id_stage_tb \
    --Mdir obj_dir -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/id_stage_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
